//--- hw/eth_rx_switch_pkg.sv
// shared widths, protocol constants, header offsets, fifo sizing and fsm state types
package eth_rx_switch_pkg;

    // stream byte and header field widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [7:0]  ip_proto_t;
    typedef logic [15:0] udp_port_t;

    // frame counters wrap at 16 bits
    typedef logic [15:0] frame_count_t;

    // byte index inside one header section
    typedef logic [5:0]  hdr_ptr_t;

    // only ipv4 carrying udp is ever a cs candidate
    localparam ethertype_t ETHERTYPE_IPV4 = 16'h0800;
    localparam ip_proto_t  IP_PROTO_UDP   = 8'h11;

    // configured udp destination ports
    localparam int NUM_MATCH_PORTS = 8;

    // header section lengths in bytes (no ip options)
    localparam hdr_ptr_t ETH_HDR_LEN = 6'd14;
    localparam hdr_ptr_t IP_HDR_LEN  = 6'd20;
    localparam hdr_ptr_t UDP_HDR_LEN = 6'd8;

    // field offsets from the start of their own section
    localparam hdr_ptr_t ETH_TYPE_OFS = 6'd12;
    localparam hdr_ptr_t IP_PROTO_OFS = 6'd9;
    localparam hdr_ptr_t UDP_DST_OFS  = 6'd2;

    // must hold the full 42 byte header while a route is pending
    localparam int FIFO_DEPTH  = 128;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // header parser states
    typedef enum logic [2:0] {
        PARSE_IDLE,
        PARSE_READ_ETH,
        PARSE_CHECK_ETH,
        PARSE_READ_IP,
        PARSE_READ_UDP,
        PARSE_WAIT_ROUTE,
        PARSE_READ_PAYLOAD
    } parse_state_t;

    // output router states
    typedef enum logic [1:0] {
        ROUTE_IDLE,
        ROUTE_SEND,
        ROUTE_UNLOCK
    } route_state_t;

endpackage

//--- hw/byte_fifo.sv
// byte_fifo: circular ingress buffer for data and last with a registered output stage
`timescale 1ns/100ps

module byte_fifo import eth_rx_switch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t in_data,
    input  logic  in_last,
    input  logic  in_valid,
    output logic  in_ready,
    output byte_t out_data,
    output logic  out_last,
    output logic  out_valid,
    input  logic  out_ready
);

    // storage holds data with last packed in the top bit
    logic [8:0]             mem [FIFO_DEPTH];
    // pointers carry one extra wrap bit
    logic [FIFO_ADDR_W:0]   wr_ptr;
    logic [FIFO_ADDR_W:0]   rd_ptr;
    logic                   mem_empty;
    logic                   mem_full;
    logic                   wr_en;
    logic                   load_out;

    // full when the low bits meet and the wrap bits differ
    assign mem_full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
                       (wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);
    assign mem_empty = (wr_ptr == rd_ptr);

    assign in_ready = !mem_full;
    assign wr_en    = in_valid && in_ready;

    // refill output register when it is free or being drained this cycle
    assign load_out = !mem_empty && (!out_valid || out_ready);

    // write side
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_W-1:0]] <= {in_last, in_data};
        end
    end

    // pointer and output valid control
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_out) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                // drained with nothing behind it
                out_valid <= 1'b0;
            end
        end
    end

    // output payload register
    // only changes on a load so it holds while the sink stalls
    always_ff @(posedge clk) begin
        if (load_out) begin
            {out_last, out_data} <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
        end
    end

endmodule

//--- hw/frame_header_parser.sv
// frame_header_parser: header-reading fsm, udp port match and route decision lock
`timescale 1ns/100ps

module frame_header_parser import eth_rx_switch_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      s_valid,
    input  byte_t     s_data,
    input  logic      s_last,
    output logic      s_ready,
    input  logic      fifo_ready,
    output logic      fifo_valid,
    output byte_t     fifo_data,
    output logic      fifo_last,
    input  udp_port_t match_port_0,
    input  udp_port_t match_port_1,
    input  udp_port_t match_port_2,
    input  udp_port_t match_port_3,
    input  udp_port_t match_port_4,
    input  udp_port_t match_port_5,
    input  udp_port_t match_port_6,
    input  udp_port_t match_port_7,
    input  logic      route_release,
    output logic      route_lock,
    output logic      route_cs
);

    parse_state_t state;
    hdr_ptr_t     hdr_ptr;
    // captured header fields used by the decision
    ethertype_t   eth_type;
    ip_proto_t    ip_proto;
    udp_port_t    udp_dst_port;
    // whole udp header seen for this frame
    logic         udp_hdr_done;
    // last byte already taken in before the decision
    logic         frame_ended;
    logic         accepting;
    logic         in_xfer;
    logic         port_hit;
    logic         route_to_cs;
    udp_port_t    match_ports [NUM_MATCH_PORTS];

    assign match_ports[0] = match_port_0;
    assign match_ports[1] = match_port_1;
    assign match_ports[2] = match_port_2;
    assign match_ports[3] = match_port_3;
    assign match_ports[4] = match_port_4;
    assign match_ports[5] = match_port_5;
    assign match_ports[6] = match_port_6;
    assign match_ports[7] = match_port_7;

    // input is open only in the reading states
    assign accepting = (state == PARSE_READ_ETH) || (state == PARSE_READ_IP) ||
                       (state == PARSE_READ_UDP) || (state == PARSE_READ_PAYLOAD);

    // bytes go straight into the fifo, nothing is stripped
    assign s_ready    = accepting && fifo_ready;
    assign fifo_valid = accepting && s_valid;
    assign fifo_data  = s_data;
    assign fifo_last  = s_last;
    assign in_xfer    = s_valid && s_ready;

    // any of the configured ports
    always_comb begin
        port_hit = 1'b0;
        for (int i = 0; i < NUM_MATCH_PORTS; i++) begin
            if (udp_dst_port == match_ports[i]) begin
                port_hit = 1'b1;
            end
        end
    end

    // truncated headers never qualify
    assign route_to_cs = udp_hdr_done && (eth_type == ETHERTYPE_IPV4) &&
                         (ip_proto == IP_PROTO_UDP) && port_hit;

    // header field capture
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            case (state)
                PARSE_READ_ETH: begin
                    if (hdr_ptr == ETH_TYPE_OFS) begin
                        eth_type[15:8] <= s_data;
                    end else if (hdr_ptr == ETH_TYPE_OFS + 6'd1) begin
                        eth_type[7:0] <= s_data;
                    end
                end
                PARSE_READ_IP: begin
                    if (hdr_ptr == IP_PROTO_OFS) begin
                        ip_proto <= s_data;
                    end
                end
                PARSE_READ_UDP: begin
                    if (hdr_ptr == UDP_DST_OFS) begin
                        udp_dst_port[15:8] <= s_data;
                    end else if (hdr_ptr == UDP_DST_OFS + 6'd1) begin
                        udp_dst_port[7:0] <= s_data;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= PARSE_IDLE;
            hdr_ptr      <= '0;
            udp_hdr_done <= 1'b0;
            frame_ended  <= 1'b0;
            route_lock   <= 1'b0;
            route_cs     <= 1'b0;
        end else begin
            // router is done with the locked frame
            if (route_release) begin
                route_lock <= 1'b0;
            end
            case (state)
                PARSE_IDLE: begin
                    hdr_ptr      <= '0;
                    udp_hdr_done <= 1'b0;
                    frame_ended  <= 1'b0;
                    state        <= PARSE_READ_ETH;
                end
                PARSE_READ_ETH: begin
                    if (in_xfer) begin
                        hdr_ptr <= hdr_ptr + 6'd1;
                        if (s_last) begin
                            frame_ended <= 1'b1;
                            state       <= PARSE_WAIT_ROUTE;
                        end else if (hdr_ptr == ETH_HDR_LEN - 6'd1) begin
                            hdr_ptr <= '0;
                            state   <= PARSE_CHECK_ETH;
                        end
                    end
                end
                PARSE_CHECK_ETH: begin
                    // non ipv4 is decided here after 14 bytes
                    if (eth_type == ETHERTYPE_IPV4) begin
                        state <= PARSE_READ_IP;
                    end else begin
                        state <= PARSE_WAIT_ROUTE;
                    end
                end
                PARSE_READ_IP: begin
                    if (in_xfer) begin
                        hdr_ptr <= hdr_ptr + 6'd1;
                        if (s_last) begin
                            frame_ended <= 1'b1;
                            state       <= PARSE_WAIT_ROUTE;
                        end else if (hdr_ptr == IP_HDR_LEN - 6'd1) begin
                            hdr_ptr <= '0;
                            // protocol byte was taken at offset 9
                            if (ip_proto == IP_PROTO_UDP) begin
                                state <= PARSE_READ_UDP;
                            end else begin
                                state <= PARSE_WAIT_ROUTE;
                            end
                        end
                    end
                end
                PARSE_READ_UDP: begin
                    if (in_xfer) begin
                        hdr_ptr <= hdr_ptr + 6'd1;
                        // a frame may end exactly on the last udp byte
                        if (hdr_ptr == UDP_HDR_LEN - 6'd1) begin
                            udp_hdr_done <= 1'b1;
                            state        <= PARSE_WAIT_ROUTE;
                        end
                        if (s_last) begin
                            frame_ended <= 1'b1;
                            state       <= PARSE_WAIT_ROUTE;
                        end
                    end
                end
                PARSE_WAIT_ROUTE: begin
                    // hold input until the previous frame is released
                    if (!route_lock) begin
                        route_lock <= 1'b1;
                        route_cs   <= route_to_cs;
                        state      <= frame_ended ? PARSE_IDLE : PARSE_READ_PAYLOAD;
                    end
                end
                PARSE_READ_PAYLOAD: begin
                    if (in_xfer && s_last) begin
                        state <= PARSE_IDLE;
                    end
                end
                default: begin
                    state <= PARSE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/frame_output_router.sv
// frame_output_router: output fsm steering the fifo stream to cs or ps, frame counters
`timescale 1ns/100ps

module frame_output_router import eth_rx_switch_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  byte_t        fifo_data,
    input  logic         fifo_last,
    input  logic         fifo_valid,
    output logic         fifo_ready,
    input  logic         route_lock,
    input  logic         route_cs,
    output logic         route_release,
    output byte_t        cs_data,
    output logic         cs_last,
    output logic         cs_valid,
    input  logic         cs_ready,
    output byte_t        ps_data,
    output logic         ps_last,
    output logic         ps_valid,
    input  logic         ps_ready,
    output frame_count_t cs_frame_count,
    output frame_count_t ps_frame_count
);

    route_state_t state;
    logic         sending;
    logic         fifo_xfer;

    // fifo is read only while a locked frame is being sent
    assign sending = (state == ROUTE_SEND);

    // route_cs stays fixed for the whole locked frame
    assign cs_valid = sending && route_cs && fifo_valid;
    assign ps_valid = sending && !route_cs && fifo_valid;

    // both outputs see the same data bus
    assign cs_data = fifo_data;
    assign cs_last = fifo_last;
    assign ps_data = fifo_data;
    assign ps_last = fifo_last;

    // ready comes back only from the selected sink
    assign fifo_ready = sending && (route_cs ? cs_ready : ps_ready);
    assign fifo_xfer  = fifo_valid && fifo_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ROUTE_IDLE;
            route_release  <= 1'b0;
            cs_frame_count <= '0;
            ps_frame_count <= '0;
        end else begin
            case (state)
                ROUTE_IDLE: begin
                    route_release <= 1'b0;
                    // wait for the parser's decision
                    if (route_lock) begin
                        state <= ROUTE_SEND;
                    end
                end
                ROUTE_SEND: begin
                    // end of frame on the chosen output
                    if (fifo_xfer && fifo_last) begin
                        route_release <= 1'b1;
                        state         <= ROUTE_UNLOCK;
                        if (route_cs) begin
                            cs_frame_count <= cs_frame_count + 1'b1;
                        end else begin
                            ps_frame_count <= ps_frame_count + 1'b1;
                        end
                    end
                end
                ROUTE_UNLOCK: begin
                    // single cycle release pulse
                    route_release <= 1'b0;
                    // old lock must drop before the next one is taken
                    if (!route_lock) begin
                        state <= ROUTE_IDLE;
                    end
                end
                default: begin
                    route_release <= 1'b0;
                    state         <= ROUTE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/eth_rx_switch.sv
// eth_rx_switch: top level wiring header parser, ingress fifo and output router
`timescale 1ns/100ps

module eth_rx_switch import eth_rx_switch_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  byte_t        s_data,
    input  logic         s_valid,
    input  logic         s_last,
    output logic         s_ready,
    input  udp_port_t    match_port_0,
    input  udp_port_t    match_port_1,
    input  udp_port_t    match_port_2,
    input  udp_port_t    match_port_3,
    input  udp_port_t    match_port_4,
    input  udp_port_t    match_port_5,
    input  udp_port_t    match_port_6,
    input  udp_port_t    match_port_7,
    output byte_t        cs_data,
    output logic         cs_valid,
    output logic         cs_last,
    input  logic         cs_ready,
    output byte_t        ps_data,
    output logic         ps_valid,
    output logic         ps_last,
    input  logic         ps_ready,
    output frame_count_t cs_frame_count,
    output frame_count_t ps_frame_count
);

    // parser to fifo
    byte_t in_data;
    logic  in_last;
    logic  in_valid;
    logic  in_ready;

    // fifo to router
    byte_t out_data;
    logic  out_last;
    logic  out_valid;
    logic  out_ready;

    // route decision handoff
    logic  route_lock;
    logic  route_cs;
    logic  route_release;

    frame_header_parser u_parser (
        .clk           (clk),
        .rst           (rst),
        .s_valid       (s_valid),
        .s_data        (s_data),
        .s_last        (s_last),
        .s_ready       (s_ready),
        .fifo_ready    (in_ready),
        .fifo_valid    (in_valid),
        .fifo_data     (in_data),
        .fifo_last     (in_last),
        .match_port_0  (match_port_0),
        .match_port_1  (match_port_1),
        .match_port_2  (match_port_2),
        .match_port_3  (match_port_3),
        .match_port_4  (match_port_4),
        .match_port_5  (match_port_5),
        .match_port_6  (match_port_6),
        .match_port_7  (match_port_7),
        .route_release (route_release),
        .route_lock    (route_lock),
        .route_cs      (route_cs)
    );

    byte_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    frame_output_router u_router (
        .clk            (clk),
        .rst            (rst),
        .fifo_data      (out_data),
        .fifo_last      (out_last),
        .fifo_valid     (out_valid),
        .fifo_ready     (out_ready),
        .route_lock     (route_lock),
        .route_cs       (route_cs),
        .route_release  (route_release),
        .cs_data        (cs_data),
        .cs_last        (cs_last),
        .cs_valid       (cs_valid),
        .cs_ready       (cs_ready),
        .ps_data        (ps_data),
        .ps_last        (ps_last),
        .ps_valid       (ps_valid),
        .ps_ready       (ps_ready),
        .cs_frame_count (cs_frame_count),
        .ps_frame_count (ps_frame_count)
    );

endmodule

//--- verification/eth_rx_switch_chk.sv
// bound protocol assertions on the switch output streams and frame counters
`timescale 1ns/100ps

module eth_rx_switch_chk import eth_rx_switch_pkg::*; (
    input logic         clk,
    input logic         rst,
    input byte_t        cs_data,
    input logic         cs_valid,
    input logic         cs_last,
    input logic         cs_ready,
    input byte_t        ps_data,
    input logic         ps_valid,
    input logic         ps_last,
    input logic         ps_ready,
    input frame_count_t cs_frame_count,
    input frame_count_t ps_frame_count
);

    // only the locked route may drive its output
    one_output_active: assert property (@(posedge clk) disable iff (rst)
        !(cs_valid && ps_valid))
        else $error("cs_valid and ps_valid high in the same cycle");

    // stalled beat holds
    cs_hold: assert property (@(posedge clk) disable iff (rst)
        (cs_valid && !cs_ready) |=> (cs_valid && $stable(cs_data) && $stable(cs_last)))
        else $error("cs beat changed while cs_ready was low");
    ps_hold: assert property (@(posedge clk) disable iff (rst)
        (ps_valid && !ps_ready) |=> (ps_valid && $stable(ps_data) && $stable(ps_last)))
        else $error("ps beat changed while ps_ready was low");

    // counters step by one per last transfer, otherwise hold
    cs_count_step: assert property (@(posedge clk) disable iff (rst)
        (cs_valid && cs_ready && cs_last) |=> (cs_frame_count == $past(cs_frame_count) + 16'd1))
        else $error("cs_frame_count did not step after a last transfer");
    cs_count_hold: assert property (@(posedge clk) disable iff (rst)
        !(cs_valid && cs_ready && cs_last) |=> $stable(cs_frame_count))
        else $error("cs_frame_count changed without a last transfer");
    ps_count_step: assert property (@(posedge clk) disable iff (rst)
        (ps_valid && ps_ready && ps_last) |=> (ps_frame_count == $past(ps_frame_count) + 16'd1))
        else $error("ps_frame_count did not step after a last transfer");
    ps_count_hold: assert property (@(posedge clk) disable iff (rst)
        !(ps_valid && ps_ready && ps_last) |=> $stable(ps_frame_count))
        else $error("ps_frame_count changed without a last transfer");

endmodule

bind eth_rx_switch eth_rx_switch_chk u_chk (
    .clk            (clk),
    .rst            (rst),
    .cs_data        (cs_data),
    .cs_valid       (cs_valid),
    .cs_last        (cs_last),
    .cs_ready       (cs_ready),
    .ps_data        (ps_data),
    .ps_valid       (ps_valid),
    .ps_last        (ps_last),
    .ps_ready       (ps_ready),
    .cs_frame_count (cs_frame_count),
    .ps_frame_count (ps_frame_count)
);

//--- verification/tb_eth_rx_switch.sv
// testbench with clock, reset, frame builder, output scoreboards and watchdog
`timescale 1ns/100ps

module tb_eth_rx_switch
    import eth_rx_switch_pkg::*;
();

    localparam logic [31:0] SEED = 32'd88728;
    localparam int NUM_MIX_FRAMES = 40;
    // eight matched frames, six ps frames, then the mix
    localparam int NUM_FRAMES = NUM_MATCH_PORTS + 6 + NUM_MIX_FRAMES;
    localparam int HDR_TOTAL = int'(ETH_HDR_LEN) + int'(IP_HDR_LEN) + int'(UDP_HDR_LEN);
    // full headers plus the longest payload
    localparam int MAX_FRAME_LEN = HDR_TOTAL + 60;
    localparam int WATCHDOG_CYCLES = 200 * NUM_FRAMES * MAX_FRAME_LEN;

    logic         clk = 1'b0;
    logic         rst;
    byte_t        s_data;
    logic         s_valid;
    logic         s_last;
    logic         s_ready;
    udp_port_t    match_port_0;
    udp_port_t    match_port_1;
    udp_port_t    match_port_2;
    udp_port_t    match_port_3;
    udp_port_t    match_port_4;
    udp_port_t    match_port_5;
    udp_port_t    match_port_6;
    udp_port_t    match_port_7;
    byte_t        cs_data;
    logic         cs_valid;
    logic         cs_last;
    logic         cs_ready = 1'b0;
    byte_t        ps_data;
    logic         ps_valid;
    logic         ps_last;
    logic         ps_ready = 1'b0;
    frame_count_t cs_frame_count;
    frame_count_t ps_frame_count;

    // expected bytes per output with last in bit 8
    logic [8:0]   cs_exp_q[$];
    logic [8:0]   ps_exp_q[$];
    frame_count_t cs_frames_exp;
    frame_count_t ps_frames_exp;
    // frame under construction
    byte_t        frame_q[$];
    string        test_name;
    logic [31:0]  rng_state;
    // separate stream so stalls do not shift frame contents
    logic [31:0]  stall_state = ~SEED;
    logic         stall_en;

    // 8 ns clock
    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // match table spread apart by 7
    function automatic udp_port_t cfg_port(input int idx);
        return 16'(5000 + 7 * idx);
    endfunction

    assign match_port_0 = cfg_port(0);
    assign match_port_1 = cfg_port(1);
    assign match_port_2 = cfg_port(2);
    assign match_port_3 = cfg_port(3);
    assign match_port_4 = cfg_port(4);
    assign match_port_5 = cfg_port(5);
    assign match_port_6 = cfg_port(6);
    assign match_port_7 = cfg_port(7);

    // cs only for complete udp over ipv4 headers with a listed port
    function automatic logic routes_to_cs(input ethertype_t et, input ip_proto_t proto,
                                          input udp_port_t dport, input int len);
        logic hit;
        int   i;
        hit = 1'b0;
        for (i = 0; i < NUM_MATCH_PORTS; i++) begin
            if (dport == cfg_port(i)) begin
                hit = 1'b1;
            end
        end
        return hit && (et == 16'h0800) && (proto == 8'h11) && (len >= HDR_TOTAL);
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic push_word(input logic [15:0] w);
        frame_q.push_back(w[15:8]);
        frame_q.push_back(w[7:0]);
    endtask

    task automatic push_random(input int n);
        logic [31:0] r;
        int          i;
        for (i = 0; i < n; i++) begin
            r = next_rand();
            frame_q.push_back(r[7:0]);
        end
    endtask

    task automatic build_frame(input ethertype_t et, input ip_proto_t proto,
                               input udp_port_t dport, input int cut_len);
        logic [31:0] r;
        int          pay_len;
        frame_q.delete();
        r = next_rand();
        pay_len = 1 + int'(r % 32'd60);
        // mac addresses then type
        push_random(12);
        push_word(et);
        // ipv4 header, no options
        frame_q.push_back(8'h45);
        frame_q.push_back(8'h00);
        push_word(16'(28 + pay_len));
        // id and flags
        push_random(4);
        frame_q.push_back(8'd64);
        frame_q.push_back(proto);
        // checksum and both addresses
        push_random(10);
        // udp source, destination, length and checksum
        push_random(2);
        push_word(dport);
        push_word(16'(8 + pay_len));
        push_random(2);
        push_random(pay_len);
        // cut short for header truncation cases
        if (cut_len > 0) begin
            while (frame_q.size() > cut_len) begin
                void'(frame_q.pop_back());
            end
        end
    endtask

    // starts on a falling edge and returns on the falling edge after the last byte
    task automatic send_frame();
        int i;
        for (i = 0; i < frame_q.size(); i++) begin
            s_data  = frame_q[i];
            s_valid = 1'b1;
            s_last  = (i == frame_q.size() - 1);
            // s_ready comes only from registers and has settled since the rising edge
            while (!s_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    task automatic run_frame(input ethertype_t et, input ip_proto_t proto,
                             input udp_port_t dport, input int cut_len);
        logic [8:0] entry;
        logic       to_cs;
        int         i;
        int         n;
        build_frame(et, proto, dport, cut_len);
        n = frame_q.size();
        to_cs = routes_to_cs(et, proto, dport, n);
        for (i = 0; i < n; i++) begin
            entry = {(i == n - 1), frame_q[i]};
            if (to_cs) begin
                cs_exp_q.push_back(entry);
            end else begin
                ps_exp_q.push_back(entry);
            end
        end
        if (to_cs) begin
            cs_frames_exp = cs_frames_exp + 16'd1;
        end else begin
            ps_frames_exp = ps_frames_exp + 16'd1;
        end
        send_frame();
    endtask

    // one transferred output byte against the head of its queue
    task automatic check_output(input logic on_cs, input byte_t data, input logic last);
        logic [8:0] exp;
        string      port;
        int         depth;
        port  = on_cs ? "cs" : "ps";
        depth = on_cs ? cs_exp_q.size() : ps_exp_q.size();
        if (depth == 0) begin
            $display("%s: byte 0x%h came out on %s with no frame expected there",
                     test_name, data, port);
            abort_run();
        end else begin
            if (on_cs) begin
                exp = cs_exp_q.pop_front();
            end else begin
                exp = ps_exp_q.pop_front();
            end
            assert (data == exp[7:0]) else begin
                $display("FAILED %s: %s data expected 0x%h, actual 0x%h",
                         test_name, port, exp[7:0], data);
                abort_run();
            end
            assert (last == exp[8]) else begin
                $display("FAILED %s: %s last expected %b, actual %b",
                         test_name, port, exp[8], last);
                abort_run();
            end
        end
    endtask

    task automatic check_counters();
        assert (cs_frame_count == cs_frames_exp) else begin
            $display("FAILED %s: cs_frame_count expected %0d, actual %0d",
                     test_name, cs_frames_exp, cs_frame_count);
            abort_run();
        end
        assert (ps_frame_count == ps_frames_exp) else begin
            $display("FAILED %s: ps_frame_count expected %0d, actual %0d",
                     test_name, ps_frames_exp, ps_frame_count);
            abort_run();
        end
    endtask

    // each outstanding byte gets 200 cycles to come out
    task automatic wait_drained();
        int limit;
        int waited;
        limit  = 200 * (cs_exp_q.size() + ps_exp_q.size());
        waited = 0;
        while (((cs_exp_q.size() != 0) || (ps_exp_q.size() != 0)) && (waited < limit)) begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
    endtask

    eth_rx_switch UUT (
        .clk            (clk),
        .rst            (rst),
        .s_data         (s_data),
        .s_valid        (s_valid),
        .s_last         (s_last),
        .s_ready        (s_ready),
        .match_port_0   (match_port_0),
        .match_port_1   (match_port_1),
        .match_port_2   (match_port_2),
        .match_port_3   (match_port_3),
        .match_port_4   (match_port_4),
        .match_port_5   (match_port_5),
        .match_port_6   (match_port_6),
        .match_port_7   (match_port_7),
        .cs_data        (cs_data),
        .cs_valid       (cs_valid),
        .cs_last        (cs_last),
        .cs_ready       (cs_ready),
        .ps_data        (ps_data),
        .ps_valid       (ps_valid),
        .ps_last        (ps_last),
        .ps_ready       (ps_ready),
        .cs_frame_count (cs_frame_count),
        .ps_frame_count (ps_frame_count)
    );

    // sink readiness is random about 3 of 4 cycles when stalls are on
    always @(negedge clk) begin
        if (stall_en) begin
            stall_state = xorshift32(stall_state);
            cs_ready = stall_state[0] | stall_state[1];
            ps_ready = stall_state[2] | stall_state[3];
        end else begin
            cs_ready = 1'b1;
            ps_ready = 1'b1;
        end
    end

    // output scoreboards compare pre-edge values
    always @(posedge clk) begin
        if (!rst && cs_valid && cs_ready) begin
            check_output(1'b1, cs_data, cs_last);
        end
        if (!rst && ps_valid && ps_ready) begin
            check_output(1'b0, ps_data, ps_last);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: frames still in flight after %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        logic [31:0] r;
        udp_port_t   hit_port;
        int          n;
        int          kind;
        rst           = 1'b1;
        s_data        = '0;
        s_valid       = 1'b0;
        s_last        = 1'b0;
        stall_en      = 1'b0;
        rng_state     = SEED;
        cs_frames_exp = '0;
        ps_frames_exp = '0;
        test_name     = "reset";
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!cs_valid && !ps_valid) else begin
            $display("FAILED %s: cs_valid ps_valid expected 00, actual %b%b",
                     test_name, cs_valid, ps_valid);
            abort_run();
        end
        check_counters();

        // one frame per table entry
        test_name = "matched_ports";
        for (n = 0; n < NUM_MATCH_PORTS; n++) begin
            run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, cfg_port(n), 0);
        end
        wait_drained();
        check_counters();

        test_name = "ps_routes";
        run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, cfg_port(0) + 16'd1, 0);
        // tcp
        run_frame(ETHERTYPE_IPV4, 8'h06, cfg_port(1), 0);
        // ipv6 type
        run_frame(16'h86dd, IP_PROTO_UDP, cfg_port(2), 0);
        // ends in eth, ip, then udp header
        run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, cfg_port(3), 9);
        run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, cfg_port(4), 25);
        run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, cfg_port(5), 38);
        wait_drained();
        check_counters();

        test_name = "random_mix";
        stall_en  = 1'b1;
        for (n = 0; n < NUM_MIX_FRAMES; n++) begin
            r        = next_rand();
            hit_port = cfg_port(int'(r[10:8]));
            kind     = int'(r[31:24]) % 6;
            case (kind)
                0, 1: run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, hit_port, 0);
                2: run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, r[23:8], 0);
                3: run_frame(ETHERTYPE_IPV4, 8'h06, hit_port, 0);
                4: run_frame(16'h0806, IP_PROTO_UDP, hit_port, 0);
                default: run_frame(ETHERTYPE_IPV4, IP_PROTO_UDP, hit_port,
                                   1 + int'(r[7:0]) % (HDR_TOTAL - 1));
            endcase
        end
        wait_drained();
        stall_en = 1'b0;
        check_counters();

        if ((cs_exp_q.size() == 0) && (ps_exp_q.size() == 0)) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("bytes left in the expected queues at the end of the run");
            abort_run();
        end
    end

endmodule

//--- verilog.f
hw/eth_rx_switch_pkg.sv
hw/byte_fifo.sv
hw/frame_header_parser.sv
hw/frame_output_router.sv
hw/eth_rx_switch.sv
verification/eth_rx_switch_chk.sv
verification/tb_eth_rx_switch.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_eth_rx_switch
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
